//--- source/ecc_geometry_pkg.sv
package ecc_geometry_pkg;

	////////////////////////////////////////////////////////////////////////////
	// block geometry
	////////////////////////////////////////////////////////////////////////////

	// bytes per ECC block
	localparam int block_bytes = 128;

	// data path width
	localparam int byte_width = 8;

	// enough bits to address every byte of a block
	localparam int index_width = $clog2(block_bytes);

	////////////////////////////////////////////////////////////////////////////
	// data and parity types
	////////////////////////////////////////////////////////////////////////////

	// one host byte
	typedef logic [byte_width-1:0] data_byte_t;

	// byte position inside the block
	typedef logic [index_width-1:0] byte_index_t;

	// parity of each byte, bit n for byte n
	typedef logic [block_bytes-1:0] line_parity_t;

endpackage

//--- source/ecc_format_pkg.sv
package ecc_format_pkg;

	////////////////////////////////////////////////////////////////////////////
	// code word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int column_code_width = 8;
	localparam int line_code_width = 16;

	// unused top bits of both codes read as ones
	localparam logic pad_value = 1'b1;

	// bits 5:0 folded column parity, 7:6 pad
	typedef logic [column_code_width-1:0] column_code_t;

	// bits 13:0 folded line parity, 15:14 pad
	typedef logic [line_code_width-1:0] line_code_t;

	////////////////////////////////////////////////////////////////////////////
	// emission
	////////////////////////////////////////////////////////////////////////////

	// tag carried with every ECC byte
	typedef enum logic [1:0] {slot_line_lo, slot_line_hi, slot_column} ecc_slot_t;

	typedef enum logic [1:0] {emit_idle, emit_line_lo, emit_line_hi, emit_column} emit_state_t;

endpackage

//--- source/parity_accumulator.sv
`timescale 1ns/1ps

module parity_accumulator
(
	input logic clk,
	input logic rst,
	input ecc_geometry_pkg::data_byte_t data_byte,
	input logic data_valid,
	input logic block_restart,
	output logic block_done,
	output ecc_geometry_pkg::data_byte_t column_parity,
	output ecc_geometry_pkg::line_parity_t line_parity
);

	ecc_geometry_pkg::byte_index_t byte_index;
	ecc_geometry_pkg::data_byte_t column_acc;
	ecc_geometry_pkg::line_parity_t line_acc;

	// accumulator values including the byte on the bus
	ecc_geometry_pkg::data_byte_t column_with_byte;
	ecc_geometry_pkg::line_parity_t line_with_byte;

	logic take_byte;
	logic last_byte;

	// restart drops a byte strobed in the same cycle
	assign take_byte = data_valid && !block_restart;
	assign last_byte = byte_index ==
		ecc_geometry_pkg::byte_index_t'(ecc_geometry_pkg::block_bytes - 1);

	always_comb
	begin
		column_with_byte = column_acc ^ data_byte;
		line_with_byte = line_acc;
		line_with_byte[byte_index] = ^data_byte;
	end

	////////////////////////////////////////////////////////////////////////////
	// running parity
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			byte_index <= '0;
			column_acc <= '0;
			line_acc <= '0;
			block_done <= 1'b0;
		end
		else
		begin
			block_done <= take_byte && last_byte;
			if (block_restart)
			begin
				byte_index <= '0;
				column_acc <= '0;
				line_acc <= '0;
			end
			else if (data_valid)
			begin
				// index wraps to 0 after the last byte
				byte_index <= byte_index + ecc_geometry_pkg::byte_index_t'(1);
				if (last_byte)
				begin
					column_acc <= '0;
					line_acc <= '0;
				end
				else
				begin
					column_acc <= column_with_byte;
					line_acc <= line_with_byte;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// block snapshot
	////////////////////////////////////////////////////////////////////////////

	// held until the next block completes
	always_ff @(posedge clk)
	begin
		if (take_byte && last_byte)
		begin
			column_parity <= column_with_byte;
			line_parity <= line_with_byte;
		end
	end

	// a block is at least 128 strobes long
	block_done_single: assert property (
		@(posedge clk) disable iff (rst)
		block_done |=> !block_done
	)
	else $error("block_done high in consecutive cycles");

endmodule

//--- source/parity_folder.sv
`timescale 1ns/1ps

module parity_folder
(
	input logic clk,
	input logic rst,
	input logic block_done,
	input ecc_geometry_pkg::data_byte_t column_parity,
	input ecc_geometry_pkg::line_parity_t line_parity,
	output logic code_valid,
	output ecc_format_pkg::column_code_t column_code,
	output ecc_format_pkg::line_code_t line_code
);

	ecc_format_pkg::column_code_t column_fold;
	ecc_format_pkg::line_code_t line_fold;

	// codes are unknown until the first fold
	logic code_seen;

	////////////////////////////////////////////////////////////////////////////
	// hamming fold
	////////////////////////////////////////////////////////////////////////////

	// address bit k of each position picks code bit 2k (bit clear) or 2k+1 (bit set)
	always_comb
	begin
		column_fold = '0;
		for (int b = 0; b < ecc_geometry_pkg::byte_width; b++)
		begin
			for (int k = 0; k < $clog2(ecc_geometry_pkg::byte_width); k++)
			begin
				if (b[k])
					column_fold[2*k+1] = column_fold[2*k+1] ^ column_parity[b];
				else
					column_fold[2*k] = column_fold[2*k] ^ column_parity[b];
			end
		end
		for (int p = 2 * $clog2(ecc_geometry_pkg::byte_width);
			p < ecc_format_pkg::column_code_width; p++)
			column_fold[p] = ecc_format_pkg::pad_value;
	end

	// same rule over the byte index
	always_comb
	begin
		line_fold = '0;
		for (int i = 0; i < ecc_geometry_pkg::block_bytes; i++)
		begin
			for (int k = 0; k < ecc_geometry_pkg::index_width; k++)
			begin
				if (i[k])
					line_fold[2*k+1] = line_fold[2*k+1] ^ line_parity[i];
				else
					line_fold[2*k] = line_fold[2*k] ^ line_parity[i];
			end
		end
		for (int p = 2 * ecc_geometry_pkg::index_width;
			p < ecc_format_pkg::line_code_width; p++)
			line_fold[p] = ecc_format_pkg::pad_value;
	end

	////////////////////////////////////////////////////////////////////////////
	// code registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			code_valid <= 1'b0;
			code_seen <= 1'b0;
		end
		else
		begin
			code_valid <= block_done;
			if (block_done)
				code_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (block_done)
		begin
			column_code <= column_fold;
			line_code <= line_fold;
		end
	end

	// pads hold through every fold and every hold period
	pad_bits_set: assert property (
		@(posedge clk) disable iff (rst)
		code_seen |->
			column_code[ecc_format_pkg::column_code_width-1 -: 2] ==
				{2{ecc_format_pkg::pad_value}} &&
			line_code[ecc_format_pkg::line_code_width-1 -: 2] ==
				{2{ecc_format_pkg::pad_value}}
	)
	else $error("ECC pad bits lost");

endmodule

//--- source/ecc_byte_emitter.sv
`timescale 1ns/1ps

module ecc_byte_emitter
(
	input logic clk,
	input logic rst,
	input logic code_valid,
	input ecc_format_pkg::column_code_t column_code,
	input ecc_format_pkg::line_code_t line_code,
	output ecc_geometry_pkg::data_byte_t ecc_byte,
	output ecc_format_pkg::ecc_slot_t ecc_slot,
	output logic ecc_valid
);

	ecc_format_pkg::emit_state_t state;

	// private copy so the folder can move on
	ecc_format_pkg::column_code_t column_q;
	ecc_format_pkg::line_code_t line_q;

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= ecc_format_pkg::emit_idle;
		else
		begin
			case (state)
				ecc_format_pkg::emit_idle:
				begin
					if (code_valid)
						state <= ecc_format_pkg::emit_line_lo;
				end
				ecc_format_pkg::emit_line_lo:
					state <= ecc_format_pkg::emit_line_hi;
				ecc_format_pkg::emit_line_hi:
					state <= ecc_format_pkg::emit_column;
				default:
					state <= ecc_format_pkg::emit_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (code_valid)
		begin
			column_q <= column_code;
			line_q <= line_code;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// byte select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (state)
			ecc_format_pkg::emit_line_lo:
			begin
				ecc_byte = line_q[ecc_geometry_pkg::byte_width-1:0];
				ecc_slot = ecc_format_pkg::slot_line_lo;
			end
			ecc_format_pkg::emit_line_hi:
			begin
				ecc_byte = line_q[ecc_format_pkg::line_code_width-1 -: ecc_geometry_pkg::byte_width];
				ecc_slot = ecc_format_pkg::slot_line_hi;
			end
			ecc_format_pkg::emit_column:
			begin
				ecc_byte = column_q;
				ecc_slot = ecc_format_pkg::slot_column;
			end
			default:
			begin
				ecc_byte = '0;
				ecc_slot = ecc_format_pkg::slot_line_lo;
			end
		endcase
	end

	assign ecc_valid = state != ecc_format_pkg::emit_idle;

	// a new code must not cut into a running emission
	no_overrun: assert property (
		@(posedge clk) disable iff (rst)
		code_valid |-> state == ecc_format_pkg::emit_idle
	)
	else $error("code_valid during ECC emission");

endmodule

//--- source/nand_ecc_gen.sv
`timescale 1ns/1ps

module nand_ecc_gen
(
	input logic clk,
	input logic rst,
	input ecc_geometry_pkg::data_byte_t data_byte,
	input logic data_valid,
	input logic block_restart,
	output ecc_geometry_pkg::data_byte_t ecc_byte,
	output ecc_format_pkg::ecc_slot_t ecc_slot,
	output logic ecc_valid
);

	// accumulator to folder
	logic block_done;
	ecc_geometry_pkg::data_byte_t column_parity;
	ecc_geometry_pkg::line_parity_t line_parity;

	// folder to emitter
	logic code_valid;
	ecc_format_pkg::column_code_t column_code;
	ecc_format_pkg::line_code_t line_code;

	parity_accumulator u_accumulator
	(
		.clk(clk),
		.rst(rst),
		.data_byte(data_byte),
		.data_valid(data_valid),
		.block_restart(block_restart),
		.block_done(block_done),
		.column_parity(column_parity),
		.line_parity(line_parity)
	);

	parity_folder u_folder
	(
		.clk(clk),
		.rst(rst),
		.block_done(block_done),
		.column_parity(column_parity),
		.line_parity(line_parity),
		.code_valid(code_valid),
		.column_code(column_code),
		.line_code(line_code)
	);

	// three bytes out, starting two cycles after block_done
	ecc_byte_emitter u_emitter
	(
		.clk(clk),
		.rst(rst),
		.code_valid(code_valid),
		.column_code(column_code),
		.line_code(line_code),
		.ecc_byte(ecc_byte),
		.ecc_slot(ecc_slot),
		.ecc_valid(ecc_valid)
	);

endmodule

//--- bench/ecc_ref_model.svh
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

// column code: xor of all bytes, then halves split by each bit-position address bit
function automatic logic [7:0] column_code_of(input logic [1023:0] blk);
	logic [7:0] col;
	logic [7:0] code;
	logic even_half;
	logic odd_half;
	col = '0;
	for (int i = 0; i < 128; i++)
		col = col ^ blk[i*8 +: 8];
	// pads at 7:6 are constant ones
	code = 8'hc0;
	for (int k = 0; k < 3; k++)
	begin
		even_half = 1'b0;
		odd_half = 1'b0;
		for (int b = 0; b < 8; b++)
		begin
			if (((b >> k) & 1) == 1)
				odd_half = odd_half ^ col[b];
			else
				even_half = even_half ^ col[b];
		end
		code[2*k] = even_half;
		code[2*k+1] = odd_half;
	end
	return code;
endfunction

// line code: byte parities split by each index address bit
function automatic logic [15:0] line_code_of(input logic [1023:0] blk);
	logic [15:0] code;
	logic even_half;
	logic odd_half;
	code = 16'hc000;
	for (int k = 0; k < 7; k++)
	begin
		even_half = 1'b0;
		odd_half = 1'b0;
		for (int i = 0; i < 128; i++)
		begin
			if (((i >> k) & 1) == 1)
				odd_half = odd_half ^ (^blk[i*8 +: 8]);
			else
				even_half = even_half ^ (^blk[i*8 +: 8]);
		end
		code[2*k] = even_half;
		code[2*k+1] = odd_half;
	end
	return code;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

//--- bench/nand_ecc_gen_tb.sv
`timescale 1ns/1ps

module nand_ecc_gen_tb;

	`include "ecc_ref_model.svh"

	logic clk;
	logic rst;
	ecc_geometry_pkg::data_byte_t data_byte;
	logic data_valid;
	logic block_restart;
	ecc_geometry_pkg::data_byte_t ecc_byte;
	ecc_format_pkg::ecc_slot_t ecc_slot;
	logic ecc_valid;

	// model of the block being filled
	logic [1023:0] cur_block;
	logic [1023:0] saved_block;
	logic [1023:0] work_block;
	int fill_count;
	logic [31:0] rng_state;
	int bytes_expected;
	int bytes_seen;
	string test_name;

	// expectation for the next rising edge, pipe holds the edges after it
	logic exp_valid;
	logic [7:0] exp_byte;
	ecc_format_pkg::ecc_slot_t exp_slot;
	logic pipe_valid [0:5];
	logic [7:0] pipe_byte [0:5];
	ecc_format_pkg::ecc_slot_t pipe_slot [0:5];

	nand_ecc_gen DUT
	(
		.clk(clk),
		.rst(rst),
		.data_byte(data_byte),
		.data_valid(data_valid),
		.block_restart(block_restart),
		.ecc_byte(ecc_byte),
		.ecc_slot(ecc_slot),
		.ecc_valid(ecc_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// output checks
	////////////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("Mismatch in %s on %s: expected %h, actual %h", test_name, what,
			expected, actual);
		$display("TEST FAIL");
		$fatal(1, "ECC output check failed");
	endtask

	// covers latency too: valid only in the three cycles of each block
	valid_timing: assert property (
		@(posedge clk) disable iff (rst)
		ecc_valid == exp_valid
	)
	else report_mismatch("ecc_valid", {7'b0, $sampled(exp_valid)}, {7'b0, $sampled(ecc_valid)});

	byte_value: assert property (
		@(posedge clk) disable iff (rst)
		ecc_valid |-> ecc_byte == exp_byte
	)
	else report_mismatch("ecc_byte", $sampled(exp_byte), $sampled(ecc_byte));

	slot_order: assert property (
		@(posedge clk) disable iff (rst)
		ecc_valid |-> ecc_slot == exp_slot
	)
	else report_mismatch("ecc_slot", {6'b0, $sampled(exp_slot)}, {6'b0, $sampled(ecc_slot)});

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic next_random(output logic [7:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state[7:0];
	endtask

	// bytes show up on the edges E0+3 to E0+5 as seen from the falling edge before E0
	task automatic schedule_codes();
		logic [15:0] line_code;
		logic [7:0] column_code;
		line_code = line_code_of(cur_block);
		column_code = column_code_of(cur_block);
		pipe_valid[2] = 1'b1;
		pipe_byte[2] = line_code[7:0];
		pipe_slot[2] = ecc_format_pkg::slot_line_lo;
		pipe_valid[3] = 1'b1;
		pipe_byte[3] = line_code[15:8];
		pipe_slot[3] = ecc_format_pkg::slot_line_hi;
		pipe_valid[4] = 1'b1;
		pipe_byte[4] = column_code;
		pipe_slot[4] = ecc_format_pkg::slot_column;
		bytes_expected = bytes_expected + 3;
	endtask

	task automatic drive_cycle(input logic valid, input logic [7:0] value, input logic restart);
		@(negedge clk);
		if (ecc_valid)
			bytes_seen++;
		exp_valid = pipe_valid[0];
		exp_byte = pipe_byte[0];
		exp_slot = pipe_slot[0];
		for (int i = 0; i < 5; i++)
		begin
			pipe_valid[i] = pipe_valid[i+1];
			pipe_byte[i] = pipe_byte[i+1];
			pipe_slot[i] = pipe_slot[i+1];
		end
		pipe_valid[5] = 1'b0;
		data_valid = valid;
		data_byte = value;
		block_restart = restart;
		// restart drops a byte strobed with it
		if (restart)
			fill_count = 0;
		else if (valid)
		begin
			cur_block[fill_count*8 +: 8] = value;
			if (fill_count == 127)
			begin
				schedule_codes();
				fill_count = 0;
			end
			else
				fill_count++;
		end
	endtask

	task automatic send_block(input logic [1023:0] blk, input logic gapped);
		logic [7:0] roll;
		int gaps;
		for (int i = 0; i < 128; i++)
		begin
			gaps = 0;
			if (gapped)
			begin
				next_random(roll);
				while (roll[1:0] == 2'b00 && gaps < 4)
				begin
					drive_cycle(1'b0, roll, 1'b0);
					gaps++;
					next_random(roll);
				end
			end
			drive_cycle(1'b1, blk[i*8 +: 8], 1'b0);
		end
	endtask

	task automatic random_block(output logic [1023:0] blk);
		logic [7:0] value;
		for (int i = 0; i < 128; i++)
		begin
			next_random(value);
			blk[i*8 +: 8] = value;
		end
	endtask

	task automatic wait_for_output();
		int cycles;
		cycles = 0;
		while (bytes_seen < bytes_expected)
		begin
			if (cycles == 20)
			begin
				$display("timeout in %s while waiting for the ECC bytes", test_name);
				$display("TEST FAIL");
				$fatal(1, "ECC output missing");
			end
			else
			begin
				drive_cycle(1'b0, 8'h00, 1'b0);
				cycles++;
			end
		end
		// a few quiet edges so a stray valid is caught
		repeat (3) drive_cycle(1'b0, 8'h00, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [7:0] roll;
		rst = 1'b1;
		data_byte = '0;
		data_valid = 1'b0;
		block_restart = 1'b0;
		cur_block = '0;
		saved_block = '0;
		work_block = '0;
		fill_count = 0;
		rng_state = 32'd25302;
		bytes_expected = 0;
		bytes_seen = 0;
		test_name = "reset";
		exp_valid = 1'b0;
		exp_byte = '0;
		exp_slot = ecc_format_pkg::slot_line_lo;
		for (int i = 0; i < 6; i++)
		begin
			pipe_valid[i] = 1'b0;
			pipe_byte[i] = '0;
			pipe_slot[i] = ecc_format_pkg::slot_line_lo;
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;

		test_name = "idle after reset";
		repeat (20) drive_cycle(1'b0, 8'h00, 1'b0);

		// only the pad bits are set
		test_name = "all zero block";
		send_block('0, 1'b0);
		wait_for_output();

		test_name = "random back to back";
		for (int b = 0; b < 4; b++)
		begin
			random_block(work_block);
			if (b == 0)
				saved_block = work_block;
			send_block(work_block, 1'b0);
		end
		wait_for_output();

		test_name = "single bit at index 37";
		work_block = '0;
		work_block[37*8 +: 8] = 8'h01;
		send_block(work_block, 1'b0);
		wait_for_output();

		test_name = "restart mid block";
		for (int i = 0; i < 50; i++)
		begin
			next_random(roll);
			drive_cycle(1'b1, roll, 1'b0);
		end
		next_random(roll);
		drive_cycle(1'b1, roll, 1'b1);
		for (int i = 0; i < 128; i++)
			work_block[i*8 +: 8] = 8'(i * 29) ^ 8'h5a;
		send_block(work_block, 1'b0);
		wait_for_output();

		test_name = "gapped input";
		send_block(saved_block, 1'b1);
		wait_for_output();

		$display("TEST PASS");
		$finish;
	end

endmodule

//--- nand_ecc_gen.f
+incdir+bench
source/ecc_geometry_pkg.sv
source/ecc_format_pkg.sv
source/parity_accumulator.sv
source/parity_folder.sv
source/ecc_byte_emitter.sv
source/nand_ecc_gen.sv
bench/nand_ecc_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nand_ecc_gen_tb \
	-f nand_ecc_gen.f -o nand_ecc_gen_sim > build.log 2>&1 ||
	{ cat build.log; echo "build failed"; exit 1; }

./obj_dir/nand_ecc_gen_sim > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
